// File: cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width
`define WORD_SIZE 16

// general registers
`define NUM_REGS 4

// pc bits used to index the target buffer
`define BTB_INDEX_BITS 4

// opcode 11 with every other field zero
`define NOP_INSTR 16'hb000

`endif

// File: cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

	typedef logic [`WORD_SIZE-1:0] word_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;
	typedef logic [7:0] imm_t;

	typedef enum logic [3:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_BGZ   = 4'd2,
		OP_BLZ   = 4'd3,
		OP_ADI   = 4'd4,
		OP_ORI   = 4'd5,
		OP_LHI   = 4'd6,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_JMP   = 4'd9,
		OP_JAL   = 4'd10,
		OP_NOP   = 4'd11,
		OP_RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} func_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_SHL, ALU_SHR, ALU_LHI
	} alu_op_e;

	// matches the low two opcode bits of the branches
	typedef enum logic [1:0] {BR_NE, BR_EQ, BR_GZ, BR_LZ} branch_kind_e;

	typedef enum logic [1:0] {PRED_SNT, PRED_WNT, PRED_WT, PRED_ST} pred_state_e;

	// operand source in execute
	localparam logic [1:0] FWD_REG = 2'd0;
	localparam logic [1:0] FWD_MEM = 2'd1;
	localparam logic [1:0] FWD_WB  = 2'd2;

endpackage

// File: alu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu import cpu_pkg::*; (
	input  word_t        i_a,
	input  word_t        i_b,
	input  alu_op_e      i_op,
	input  branch_kind_e i_branch_kind,
	output word_t        o_result,
	output logic         o_bcond
);

	localparam int HALF = `WORD_SIZE / 2;

	always_comb begin
		case (i_op)
			ALU_ADD: o_result = i_a + i_b;
			ALU_SUB: o_result = i_a - i_b;
			ALU_AND: o_result = i_a & i_b;
			ALU_OR:  o_result = i_a | i_b;
			ALU_NOT: o_result = ~i_a;
			ALU_SHL: o_result = {i_a[`WORD_SIZE-2:0], 1'b0};
			// arithmetic, sign bit kept
			ALU_SHR: o_result = {i_a[`WORD_SIZE-1], i_a[`WORD_SIZE-1:1]};
			ALU_LHI: o_result = {i_b[HALF-1:0], {HALF{1'b0}}};
			default: o_result = '0;
		endcase
	end

	// signed compares, only a is tested for gz and lz
	always_comb begin
		case (i_branch_kind)
			BR_NE:   o_bcond = i_a != i_b;
			BR_EQ:   o_bcond = i_a == i_b;
			BR_GZ:   o_bcond = !i_a[`WORD_SIZE-1] && i_a != '0;
			BR_LZ:   o_bcond = i_a[`WORD_SIZE-1];
			default: o_bcond = 1'b0;
		endcase
	end

endmodule

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit import cpu_pkg::*; (
	input  opcode_e      i_opcode,
	input  func_e        i_func,
	output alu_op_e      o_alu_op,
	output logic         o_alu_src_imm,
	output logic         o_imm_zero_ext,
	output logic         o_is_branch,
	output branch_kind_e o_branch_kind,
	output logic         o_is_jump,
	output logic         o_mem_read,
	output logic         o_mem_write,
	output logic         o_reg_write,
	output logic         o_dest_rt,
	output logic         o_dest_link,
	output logic         o_wb_from_mem,
	output logic         o_wb_link,
	output logic         o_is_wwd,
	output logic         o_is_halt,
	output logic         o_is_valid
);

	always_comb begin
		o_alu_op       = ALU_ADD;
		o_alu_src_imm  = 1'b0;
		o_imm_zero_ext = 1'b0;
		o_is_branch    = 1'b0;
		o_branch_kind  = BR_NE;
		o_is_jump      = 1'b0;
		o_mem_read     = 1'b0;
		o_mem_write    = 1'b0;
		o_reg_write    = 1'b0;
		o_dest_rt      = 1'b0;
		o_dest_link    = 1'b0;
		o_wb_from_mem  = 1'b0;
		o_wb_link      = 1'b0;
		o_is_wwd       = 1'b0;
		o_is_halt      = 1'b0;
		o_is_valid     = 1'b1;
		case (i_opcode)
			OP_BNE: begin
				o_is_branch   = 1'b1;
				o_branch_kind = BR_NE;
			end
			OP_BEQ: begin
				o_is_branch   = 1'b1;
				o_branch_kind = BR_EQ;
			end
			OP_BGZ: begin
				o_is_branch   = 1'b1;
				o_branch_kind = BR_GZ;
			end
			OP_BLZ: begin
				o_is_branch   = 1'b1;
				o_branch_kind = BR_LZ;
			end
			OP_ADI, OP_ORI, OP_LHI, OP_LWD: begin
				o_alu_src_imm = 1'b1;
				o_reg_write   = 1'b1;
				o_dest_rt     = 1'b1;
				o_imm_zero_ext = i_opcode == OP_ORI;
				o_mem_read    = i_opcode == OP_LWD;
				o_wb_from_mem = i_opcode == OP_LWD;
				if (i_opcode == OP_ORI) begin
					o_alu_op = ALU_OR;
				end else if (i_opcode == OP_LHI) begin
					o_alu_op = ALU_LHI;
				end
			end
			OP_SWD: begin
				o_alu_src_imm = 1'b1;
				o_mem_write   = 1'b1;
			end
			OP_JMP: o_is_jump = 1'b1;
			// link goes to register 2
			OP_JAL: begin
				o_is_jump   = 1'b1;
				o_reg_write = 1'b1;
				o_dest_link = 1'b1;
				o_wb_link   = 1'b1;
			end
			OP_RTYPE: begin
				o_reg_write = 1'b1;
				case (i_func)
					FN_ADD: o_alu_op = ALU_ADD;
					FN_SUB: o_alu_op = ALU_SUB;
					FN_AND: o_alu_op = ALU_AND;
					FN_ORR: o_alu_op = ALU_OR;
					FN_NOT: o_alu_op = ALU_NOT;
					FN_SHL: o_alu_op = ALU_SHL;
					FN_SHR: o_alu_op = ALU_SHR;
					FN_WWD: begin
						o_reg_write = 1'b0;
						o_is_wwd    = 1'b1;
					end
					FN_HLT: begin
						o_reg_write = 1'b0;
						o_is_halt   = 1'b1;
					end
					default: begin
						o_reg_write = 1'b0;
						o_is_valid  = 1'b0;
					end
				endcase
			end
			// bubble and unknown opcodes
			default: o_is_valid = 1'b0;
		endcase
	end

endmodule

// File: register_file.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module register_file import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  reg_addr_t i_read1,
	input  reg_addr_t i_read2,
	input  reg_addr_t i_dest,
	input  logic      i_write,
	input  word_t     i_write_data,
	output word_t     o_read_data1,
	output word_t     o_read_data2
);

	word_t regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_write) begin
			regs[i_dest] <= i_write_data;
		end
	end

	// old value during a write, cpu bypasses
	assign o_read_data1 = regs[i_read1];
	assign o_read_data2 = regs[i_read2];

endmodule

// File: branch_predictor.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module branch_predictor import cpu_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  word_t       i_fetch_pc,
	input  logic        i_update,
	input  word_t       i_update_pc,
	input  word_t       i_update_target,
	input  logic        i_actual_taken,
	input  pred_state_e i_prev_state,
	output word_t       o_next_pc,
	output pred_state_e o_state,
	output logic        o_taken
);

	localparam int ENTRIES  = 1 << `BTB_INDEX_BITS;
	localparam int TAG_BITS = `WORD_SIZE - `BTB_INDEX_BITS;

	logic                       valid [ENTRIES];
	logic [TAG_BITS-1:0]        tags [ENTRIES];
	word_t                      targets [ENTRIES];
	pred_state_e                counters [ENTRIES];
	logic [`BTB_INDEX_BITS-1:0] fetch_idx;
	logic [`BTB_INDEX_BITS-1:0] update_idx;
	logic                       hit;
	pred_state_e                next_state;

	assign fetch_idx  = i_fetch_pc[`BTB_INDEX_BITS-1:0];
	assign update_idx = i_update_pc[`BTB_INDEX_BITS-1:0];
	assign hit = valid[fetch_idx] && tags[fetch_idx] == i_fetch_pc[`WORD_SIZE-1:`BTB_INDEX_BITS];

	// a miss looks like weakly not-taken
	assign o_state   = hit ? counters[fetch_idx] : PRED_WNT;
	assign o_taken   = o_state == PRED_WT || o_state == PRED_ST;
	assign o_next_pc = o_taken ? targets[fetch_idx] : i_fetch_pc + word_t'(1);

	// saturating step from the state seen at fetch
	always_comb begin
		next_state = i_prev_state;
		case (i_prev_state)
			PRED_SNT: next_state = i_actual_taken ? PRED_WNT : PRED_SNT;
			PRED_WNT: next_state = i_actual_taken ? PRED_WT : PRED_SNT;
			PRED_WT:  next_state = i_actual_taken ? PRED_ST : PRED_WNT;
			PRED_ST:  next_state = i_actual_taken ? PRED_ST : PRED_WT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < ENTRIES; i++) begin
				valid[i] <= 1'b0;
			end
		end else if (i_update) begin
			valid[update_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_update) begin
			tags[update_idx]     <= i_update_pc[`WORD_SIZE-1:`BTB_INDEX_BITS];
			targets[update_idx]  <= i_update_target;
			counters[update_idx] <= next_state;
		end
	end

	a_state_known: assert property (@(posedge clk) disable iff (!reset_n)
		!$isunknown(o_state));

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
	input  reg_addr_t  i_rs_id,
	input  reg_addr_t  i_rt_id,
	input  reg_addr_t  i_rs_ex,
	input  reg_addr_t  i_rt_ex,
	input  reg_addr_t  i_dest_ex,
	input  reg_addr_t  i_dest_mem,
	input  reg_addr_t  i_dest_wb,
	input  logic       i_uses_rt_id,
	input  logic       i_mem_read_ex,
	input  logic       i_reg_write_mem,
	input  logic       i_reg_write_wb,
	output logic       o_stall,
	output logic [1:0] o_fwd_a,
	output logic [1:0] o_fwd_b,
	output logic       o_wb_bypass1,
	output logic       o_wb_bypass2
);

	// newer producer wins
	function automatic logic [1:0] fwd_select(input reg_addr_t src);
		if (i_reg_write_mem && i_dest_mem == src) begin
			return FWD_MEM;
		end else if (i_reg_write_wb && i_dest_wb == src) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	// load data is not ready for the next instruction
	assign o_stall = i_mem_read_ex &&
		(i_dest_ex == i_rs_id || (i_uses_rt_id && i_dest_ex == i_rt_id));

	assign o_fwd_a = fwd_select(i_rs_ex);
	assign o_fwd_b = fwd_select(i_rt_ex);

	// register file write lands too late for decode
	assign o_wb_bypass1 = i_reg_write_wb && i_dest_wb == i_rs_id;
	assign o_wb_bypass2 = i_reg_write_wb && i_dest_wb == i_rt_id;

endmodule

// File: cpu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu import cpu_pkg::*; (
	input  logic  clk,
	input  logic  reset_n,
	input  word_t i_imem_data,
	input  word_t i_dmem_rdata,
	output word_t o_imem_addr,
	output word_t o_dmem_addr,
	output word_t o_dmem_wdata,
	output logic  o_dmem_read,
	output logic  o_dmem_write,
	output word_t o_output_port,
	output word_t o_num_inst,
	output logic  o_is_halted
);

	word_t pc, pred_next_pc;
	pred_state_e pred_state;
	logic pred_taken, stall;
	// IF/ID
	word_t id_instr, id_pc, id_pc_plus1, id_imm_sext, id_imm_ext, id_target;
	word_t rf_read1, rf_read2, id_read1, id_read2;
	logic id_taken, id_kill, id_uses_rt, wb_bypass1, wb_bypass2;
	pred_state_e id_pred_state;
	reg_addr_t id_rs, id_rt, id_dest;
	alu_op_e id_alu_op;
	branch_kind_e id_branch_kind;
	logic id_alu_src_imm, id_imm_zero_ext, id_is_branch, id_is_jump, id_mem_read;
	logic id_mem_write, id_reg_write, id_dest_rt, id_dest_link, id_wb_from_mem;
	logic id_wb_link, id_is_wwd, id_is_halt, id_valid;
	// ID/EX
	word_t ex_read1, ex_read2, ex_imm, ex_target, ex_pc, ex_src_a, ex_src_b, ex_alu_out;
	word_t ex_redirect_pc;
	reg_addr_t ex_rs, ex_rt, ex_dest;
	alu_op_e ex_alu_op;
	branch_kind_e ex_branch_kind;
	pred_state_e ex_pred_state;
	logic [1:0] fwd_a, fwd_b;
	logic ex_alu_src_imm, ex_taken, ex_wb_from_mem, ex_wb_link, ex_is_branch, ex_is_jump;
	logic ex_mem_read, ex_mem_write, ex_reg_write, ex_is_wwd, ex_is_halt, ex_valid;
	logic ex_bcond, ex_actual_taken, ex_mispredict;
	// EX/MEM
	word_t mem_alu, mem_data, mem_pc, mem_fwd_value, mem_result;
	reg_addr_t mem_dest;
	logic mem_wb_from_mem, mem_wb_link, mem_is_wwd, mem_mem_read, mem_mem_write;
	logic mem_reg_write, mem_is_halt, mem_valid;
	// MEM/WB
	word_t wb_value;
	reg_addr_t wb_dest;
	logic wb_reg_write, wb_is_wwd, wb_is_halt, wb_valid;

	function automatic word_t fwd_value(input logic [1:0] sel, input word_t reg_val,
		input word_t mem_val, input word_t wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	branch_predictor u_predictor (
		.clk(clk), .reset_n(reset_n), .i_fetch_pc(pc),
		.i_update((ex_is_branch | ex_is_jump) & ~o_is_halted), .i_update_pc(ex_pc),
		.i_update_target(ex_target), .i_actual_taken(ex_actual_taken),
		.i_prev_state(ex_pred_state), .o_next_pc(pred_next_pc), .o_state(pred_state),
		.o_taken(pred_taken)
	);

	assign o_imem_addr = pc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			id_instr <= `NOP_INSTR;
		end else if (!o_is_halted) begin
			if (ex_mispredict) begin
				pc <= ex_redirect_pc;
				id_instr <= `NOP_INSTR;
			end else if (!stall) begin
				pc <= pred_next_pc;
				id_instr <= i_imem_data;
				id_pc <= pc;
				id_taken <= pred_taken;
				id_pred_state <= pred_state;
			end
		end
	end

	assign id_rs = id_instr[11:10];
	assign id_rt = id_instr[9:8];

	control_unit u_control (
		.i_opcode(opcode_e'(id_instr[15:12])), .i_func(func_e'(id_instr[5:0])),
		.o_alu_op(id_alu_op), .o_alu_src_imm(id_alu_src_imm), .o_imm_zero_ext(id_imm_zero_ext),
		.o_is_branch(id_is_branch), .o_branch_kind(id_branch_kind), .o_is_jump(id_is_jump),
		.o_mem_read(id_mem_read), .o_mem_write(id_mem_write), .o_reg_write(id_reg_write),
		.o_dest_rt(id_dest_rt), .o_dest_link(id_dest_link), .o_wb_from_mem(id_wb_from_mem),
		.o_wb_link(id_wb_link), .o_is_wwd(id_is_wwd), .o_is_halt(id_is_halt),
		.o_is_valid(id_valid)
	);

	register_file u_regs (
		.clk(clk), .reset_n(reset_n), .i_read1(id_rs), .i_read2(id_rt), .i_dest(wb_dest),
		.i_write(wb_reg_write & ~o_is_halted), .i_write_data(wb_value),
		.o_read_data1(rf_read1), .o_read_data2(rf_read2)
	);

	// rt is only a source for these
	assign id_uses_rt = id_mem_write | (id_is_branch & id_branch_kind inside {BR_NE, BR_EQ}) |
		(id_reg_write & ~id_alu_src_imm & ~id_dest_link &
		id_alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR});

	hazard_unit u_hazard (
		.i_rs_id(id_rs), .i_rt_id(id_rt), .i_rs_ex(ex_rs), .i_rt_ex(ex_rt),
		.i_dest_ex(ex_dest), .i_dest_mem(mem_dest), .i_dest_wb(wb_dest),
		.i_uses_rt_id(id_uses_rt), .i_mem_read_ex(ex_mem_read),
		.i_reg_write_mem(mem_reg_write), .i_reg_write_wb(wb_reg_write), .o_stall(stall),
		.o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_wb_bypass1(wb_bypass1), .o_wb_bypass2(wb_bypass2)
	);

	assign id_read1 = wb_bypass1 ? wb_value : rf_read1;
	assign id_read2 = wb_bypass2 ? wb_value : rf_read2;
	assign id_pc_plus1 = id_pc + word_t'(1);
	assign id_imm_sext = {{(`WORD_SIZE - $bits(imm_t)){id_instr[7]}}, id_instr[7:0]};
	assign id_imm_ext = id_imm_zero_ext ? word_t'(imm_t'(id_instr[7:0])) : id_imm_sext;
	assign id_target = id_is_jump ? {id_pc_plus1[`WORD_SIZE-1:12], id_instr[11:0]}
		: id_pc_plus1 + id_imm_sext;
	assign id_dest = id_dest_link ? reg_addr_t'(2) : (id_dest_rt ? id_rt : id_instr[7:6]);
	assign id_kill = stall | ex_mispredict;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			{ex_is_branch, ex_is_jump, ex_mem_read, ex_mem_write} <= '0;
			{ex_reg_write, ex_is_wwd, ex_is_halt, ex_valid} <= '0;
		end else if (!o_is_halted) begin
			ex_is_branch <= id_is_branch & ~id_kill;
			ex_is_jump <= id_is_jump & ~id_kill;
			ex_mem_read <= id_mem_read & ~id_kill;
			ex_mem_write <= id_mem_write & ~id_kill;
			ex_reg_write <= id_reg_write & ~id_kill;
			ex_is_wwd <= id_is_wwd & ~id_kill;
			ex_is_halt <= id_is_halt & ~id_kill;
			ex_valid <= id_valid & ~id_kill;
			ex_read1 <= id_read1;
			ex_read2 <= id_read2;
			ex_imm <= id_imm_ext;
			ex_target <= id_target;
			ex_pc <= id_pc;
			ex_rs <= id_rs;
			ex_rt <= id_rt;
			ex_dest <= id_dest;
			ex_alu_op <= id_alu_op;
			ex_alu_src_imm <= id_alu_src_imm;
			ex_branch_kind <= id_branch_kind;
			ex_pred_state <= id_pred_state;
			ex_taken <= id_taken;
			ex_wb_from_mem <= id_wb_from_mem;
			ex_wb_link <= id_wb_link;
		end
	end

	assign ex_src_a = fwd_value(fwd_a, ex_read1, mem_fwd_value, wb_value);
	assign ex_src_b = fwd_value(fwd_b, ex_read2, mem_fwd_value, wb_value);

	alu u_alu (
		.i_a(ex_src_a), .i_b(ex_alu_src_imm ? ex_imm : ex_src_b), .i_op(ex_alu_op),
		.i_branch_kind(ex_branch_kind), .o_result(ex_alu_out), .o_bcond(ex_bcond)
	);

	// targets are fixed per pc, so only the direction can be wrong
	assign ex_actual_taken = ex_is_jump | (ex_is_branch & ex_bcond);
	assign ex_mispredict = (ex_is_branch | ex_is_jump) & (ex_actual_taken != ex_taken);
	assign ex_redirect_pc = ex_actual_taken ? ex_target : ex_pc + word_t'(1);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			{mem_is_wwd, mem_mem_read, mem_mem_write} <= '0;
			{mem_reg_write, mem_is_halt, mem_valid} <= '0;
		end else if (!o_is_halted) begin
			{mem_is_wwd, mem_mem_read, mem_mem_write} <= {ex_is_wwd, ex_mem_read, ex_mem_write};
			{mem_reg_write, mem_is_halt, mem_valid} <= {ex_reg_write, ex_is_halt, ex_valid};
			mem_alu <= ex_alu_out;
			// store data, or the value that WWD outputs
			mem_data <= ex_is_wwd ? ex_src_a : ex_src_b;
			mem_pc <= ex_pc;
			mem_dest <= ex_dest;
			mem_wb_from_mem <= ex_wb_from_mem;
			mem_wb_link <= ex_wb_link;
		end
	end

	assign o_dmem_addr = mem_alu;
	assign o_dmem_wdata = mem_data;
	assign o_dmem_read = mem_mem_read & ~o_is_halted;
	assign o_dmem_write = mem_mem_write & ~o_is_halted;
	assign mem_fwd_value = mem_wb_link ? mem_pc + word_t'(1) : mem_alu;
	assign mem_result = mem_wb_from_mem ? i_dmem_rdata : (mem_is_wwd ? mem_data : mem_fwd_value);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			{wb_reg_write, wb_is_wwd, wb_is_halt, wb_valid} <= '0;
			o_num_inst <= '0;
			o_output_port <= '0;
			o_is_halted <= 1'b0;
		end else if (!o_is_halted) begin
			{wb_reg_write, wb_is_wwd, wb_is_halt, wb_valid} <=
				{mem_reg_write, mem_is_wwd, mem_is_halt, mem_valid};
			wb_value <= mem_result;
			wb_dest <= mem_dest;
			if (wb_valid) begin
				o_num_inst <= o_num_inst + word_t'(1);
			end
			if (wb_is_wwd) begin
				o_output_port <= wb_value;
			end
			o_is_halted <= wb_is_halt;
		end
	end

	a_dmem_excl: assert property (@(posedge clk) disable iff (!reset_n)
		!(o_dmem_read && o_dmem_write));

endmodule

// File: cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb import cpu_pkg::*; ();

	localparam int NUM_PROGS = 20;
	localparam int MAX_LEN = 48;
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 1 << `WORD_SIZE;
	localparam int RESET_CYCLES = 16;
	localparam int HALT_CYCLES = 20;

	logic clk;
	logic reset_n;
	word_t i_imem_data;
	word_t i_dmem_rdata;
	word_t o_imem_addr;
	word_t o_dmem_addr;
	word_t o_dmem_wdata;
	logic o_dmem_read;
	logic o_dmem_write;
	word_t o_output_port;
	word_t o_num_inst;
	logic o_is_halted;

	word_t programs [NUM_PROGS][MAX_LEN];
	int prog_len [NUM_PROGS];
	word_t imem [IMEM_DEPTH];
	word_t dmem [DMEM_DEPTH];
	word_t model_mem [DMEM_DEPTH];
	word_t model_regs [`NUM_REGS];
	word_t exp_out [$];
	word_t exp_store_addr [$];
	word_t exp_store_data [$];
	word_t exp_load_addr [$];
	int exp_count;
	word_t last_port;
	int cycles = 0;
	int cycle_limit = 0;

	cpu cpu_i (
		.clk(clk), .reset_n(reset_n), .i_imem_data(i_imem_data),
		.i_dmem_rdata(i_dmem_rdata), .o_imem_addr(o_imem_addr), .o_dmem_addr(o_dmem_addr),
		.o_dmem_wdata(o_dmem_wdata), .o_dmem_read(o_dmem_read), .o_dmem_write(o_dmem_write),
		.o_output_port(o_output_port), .o_num_inst(o_num_inst), .o_is_halted(o_is_halted)
	);

	always #10 clk = ~clk;

	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: the processor did not halt within %0d cycles", cycle_limit);
			stop_run();
		end
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	function automatic word_t enc_reg(func_e fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
		return {OP_RTYPE, rs, rt, rd, fn};
	endfunction

	function automatic word_t enc_imm(opcode_e op, reg_addr_t rs, reg_addr_t rt, imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t enc_jump(opcode_e op, logic [11:0] target);
		return {op, target};
	endfunction

	// odd multiplier makes every address bit matter
	function automatic word_t fill_value(word_t addr);
		return (addr * 16'h9e37) ^ 16'h5ac3;
	endfunction

	function automatic word_t random_instr(int pos, int len);
		func_e alu_funcs [7] = '{FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_SHL, FN_SHR};
		opcode_e imm_ops [5] = '{OP_ADI, OP_ORI, OP_LHI, OP_LWD, OP_SWD};
		opcode_e br_ops [4] = '{OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ};
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		int target;
		int kind;
		int pick;
		rs = reg_addr_t'($urandom_range(0, 3));
		rt = reg_addr_t'($urandom_range(0, 3));
		rd = reg_addr_t'($urandom_range(0, 3));
		// forward only and never past the HLT
		target = $urandom_range(pos + 1, len - 1);
		kind = $urandom_range(0, 15);
		if (kind < 6) begin
			return enc_reg(alu_funcs[$urandom_range(0, 6)], rs, rt, rd);
		end else if (kind < 8) begin
			return enc_reg(FN_WWD, rs, rt, rd);
		end else if (kind < 12) begin
			pick = $urandom_range(0, 4);
			// small offsets so loads often meet earlier stores
			if (imm_ops[pick] == OP_LWD || imm_ops[pick] == OP_SWD) begin
				return enc_imm(imm_ops[pick], rs, rt, imm_t'($urandom_range(0, 7)));
			end
			return enc_imm(imm_ops[pick], rs, rt, imm_t'($urandom));
		end else if (kind < 14) begin
			return enc_imm(br_ops[$urandom_range(0, 3)], rs, rt, imm_t'(target - pos - 1));
		end else if (kind == 14) begin
			return enc_jump(OP_JMP, 12'(target));
		end
		return enc_jump(OP_JAL, 12'(target));
	endfunction

	task automatic build_programs();
		int len;
		// counter runs down from 12 with a load-use inside the loop
		programs[0][0] = enc_imm(OP_ADI, 2'd0, 2'd1, 8'd12);
		programs[0][1] = enc_imm(OP_ADI, 2'd1, 2'd1, 8'hff);
		programs[0][2] = enc_reg(FN_WWD, 2'd1, 2'd0, 2'd0);
		programs[0][3] = enc_imm(OP_SWD, 2'd1, 2'd1, 8'h10);
		programs[0][4] = enc_imm(OP_LWD, 2'd1, 2'd3, 8'h10);
		programs[0][5] = enc_reg(FN_ADD, 2'd2, 2'd3, 2'd2);
		programs[0][6] = enc_imm(OP_BNE, 2'd1, 2'd0, 8'hfa);
		programs[0][7] = enc_reg(FN_WWD, 2'd2, 2'd0, 2'd0);
		programs[0][8] = enc_reg(FN_HLT, 2'd0, 2'd0, 2'd0);
		prog_len[0] = 9;
		for (int p = 1; p < NUM_PROGS; p++) begin
			len = $urandom_range(8, MAX_LEN);
			for (int i = 0; i < len - 1; i++) begin
				programs[p][i] = random_instr(i, len);
			end
			programs[p][len - 1] = enc_reg(FN_HLT, 2'd0, 2'd0, 2'd0);
			prog_len[p] = len;
		end
	endtask

	// instruction-level reference stepping one instruction at a time
	task automatic run_model(input int p, output int steps);
		word_t pc;
		word_t instr;
		word_t a;
		word_t b;
		word_t addr;
		word_t imm_s;
		word_t last_out;
		opcode_e op;
		func_e fn;
		reg_addr_t rd;
		reg_addr_t rt;
		logic done;
		exp_out.delete();
		exp_store_addr.delete();
		exp_store_data.delete();
		exp_load_addr.delete();
		for (int i = 0; i < `NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < DMEM_DEPTH; i++) begin
			model_mem[i] = fill_value(word_t'(i));
		end
		pc = '0;
		steps = 0;
		done = 1'b0;
		last_out = '0;
		while (!done) begin
			if (steps > 4096) begin
				$display("the reference model did not reach HLT in program %0d", p);
				stop_run();
			end
			instr = (pc < word_t'(prog_len[p])) ? programs[p][pc[5:0]] : `NOP_INSTR;
			op = opcode_e'(instr[15:12]);
			fn = func_e'(instr[5:0]);
			rt = instr[9:8];
			rd = instr[7:6];
			a = model_regs[instr[11:10]];
			b = model_regs[rt];
			imm_s = {{8{instr[7]}}, instr[7:0]};
			addr = a + imm_s;
			steps++;
			pc = pc + 16'd1;
			case (op)
				OP_RTYPE: begin
					case (fn)
						FN_ADD: model_regs[rd] = a + b;
						FN_SUB: model_regs[rd] = a - b;
						FN_AND: model_regs[rd] = a & b;
						FN_ORR: model_regs[rd] = a | b;
						FN_NOT: model_regs[rd] = ~a;
						FN_SHL: model_regs[rd] = a << 1;
						FN_SHR: model_regs[rd] = word_t'($signed(a) >>> 1);
						// the port only shows a change
						FN_WWD: begin
							if (a != last_out) begin
								exp_out.push_back(a);
								last_out = a;
							end
						end
						FN_HLT: done = 1'b1;
						default: ;
					endcase
				end
				OP_ADI: model_regs[rt] = a + imm_s;
				OP_ORI: model_regs[rt] = a | {8'h00, instr[7:0]};
				OP_LHI: model_regs[rt] = {instr[7:0], 8'h00};
				OP_LWD: begin
					model_regs[rt] = model_mem[addr];
					exp_load_addr.push_back(addr);
				end
				OP_SWD: begin
					model_mem[addr] = b;
					exp_store_addr.push_back(addr);
					exp_store_data.push_back(b);
				end
				OP_BNE: pc = (a != b) ? pc + imm_s : pc;
				OP_BEQ: pc = (a == b) ? pc + imm_s : pc;
				OP_BGZ: pc = ($signed(a) > 16'sd0) ? pc + imm_s : pc;
				OP_BLZ: pc = ($signed(a) < 16'sd0) ? pc + imm_s : pc;
				OP_JMP: pc = {pc[15:12], instr[11:0]};
				OP_JAL: begin
					model_regs[2] = pc;
					pc = {pc[15:12], instr[11:0]};
				end
				default: ;
			endcase
		end
	endtask

	task automatic load_program(input int p);
		for (int i = 0; i < IMEM_DEPTH; i++) begin
			imem[i] = (i < prog_len[p]) ? programs[p][i] : `NOP_INSTR;
		end
		for (int i = 0; i < DMEM_DEPTH; i++) begin
			dmem[i] = fill_value(word_t'(i));
		end
	endtask

	task automatic serve_memory();
		i_imem_data = (o_imem_addr[15:8] == '0) ? imem[o_imem_addr[7:0]] : `NOP_INSTR;
		i_dmem_rdata = dmem[o_dmem_addr];
	endtask

	task automatic observe_cycle();
		if (o_dmem_read) begin
			if (exp_load_addr.size() == 0) begin
				$display("at %0t a load from %h happened that the program never makes",
					$time, o_dmem_addr);
				stop_run();
			end
			check_word("o_dmem_addr", o_dmem_addr, exp_load_addr.pop_front());
		end
		if (o_dmem_write) begin
			if (exp_store_addr.size() == 0) begin
				$display("at %0t a store to %h happened that the program never makes",
					$time, o_dmem_addr);
				stop_run();
			end
			check_word("o_dmem_addr", o_dmem_addr, exp_store_addr.pop_front());
			check_word("o_dmem_wdata", o_dmem_wdata, exp_store_data.pop_front());
			dmem[o_dmem_addr] = o_dmem_wdata;
		end
		if (o_output_port != last_port) begin
			if (exp_out.size() == 0) begin
				$display("at %0t the output port changed more often than the program writes it",
					$time);
				stop_run();
			end
			check_word("o_output_port", o_output_port, exp_out.pop_front());
			last_port = o_output_port;
		end
	endtask

	task automatic run_program(input int p);
		word_t halt_count;
		word_t halt_port;
		word_t halt_pc;
		load_program(p);
		run_model(p, exp_count);
		reset_n = 1'b0;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			serve_memory();
		end
		check_word("o_num_inst", o_num_inst, '0);
		check_word("o_output_port", o_output_port, '0);
		check_word("o_imem_addr", o_imem_addr, '0);
		check_bit("o_is_halted", o_is_halted, 1'b0);
		check_bit("o_dmem_read", o_dmem_read, 1'b0);
		check_bit("o_dmem_write", o_dmem_write, 1'b0);
		last_port = '0;
		reset_n = 1'b1;
		while (!o_is_halted) begin
			@(negedge clk);
			observe_cycle();
			serve_memory();
		end
		check_word("o_num_inst", o_num_inst, word_t'(exp_count));
		if (exp_out.size() != 0 || exp_store_addr.size() != 0 || exp_load_addr.size() != 0) begin
			$display("program %0d halted with %0d outputs, %0d stores and %0d loads missing",
				p, exp_out.size(), exp_store_addr.size(), exp_load_addr.size());
			stop_run();
		end
		halt_count = o_num_inst;
		halt_port = o_output_port;
		halt_pc = o_imem_addr;
		// everything frozen after the halt
		repeat (HALT_CYCLES) begin
			@(negedge clk);
			check_bit("o_is_halted", o_is_halted, 1'b1);
			check_word("o_num_inst", o_num_inst, halt_count);
			check_word("o_output_port", o_output_port, halt_port);
			check_word("o_imem_addr", o_imem_addr, halt_pc);
			check_bit("o_dmem_read", o_dmem_read, 1'b0);
			check_bit("o_dmem_write", o_dmem_write, 1'b0);
			serve_memory();
		end
	endtask

	initial begin
		int steps;
		int longest;
		clk = 1'b0;
		reset_n = 1'b0;
		i_imem_data = `NOP_INSTR;
		i_dmem_rdata = '0;
		void'($urandom(5));
		build_programs();
		longest = 0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			run_model(p, steps);
			if (steps > longest) begin
				longest = steps;
			end
		end
		cycle_limit = NUM_PROGS * (4 * longest + 60);
		for (int p = 0; p < NUM_PROGS; p++) begin
			run_program(p);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

// File: cpu.f
+incdir+.
cpu_pkg.sv
alu.sv
control_unit.sv
register_file.sv
branch_predictor.sv
hazard_unit.sv
cpu.sv
cpu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f cpu.f -o cpu_sim &&
./obj_dir/cpu_sim || { echo "simulation failed"; exit 1; }
